//--- include/tcp_tx_macros.svh
`ifndef TCP_TX_MACROS_SVH
`define TCP_TX_MACROS_SVH

// ************************************************************
// NoC flit geometry
// ************************************************************

`define NOC_DATA_WIDTH      64                  // One header flit.
`define NOC_XY_W            4                   // Mesh coordinate.

// ************************************************************
// TCP transmit tile fields
// ************************************************************

`define TCP_FLOWID_W        8                   // Flow identifier.
`define TCP_TX_PTR_W        16                  // Transmit buffer pointer.
`define TCP_TX_MSG_TYPE_W   8                   // Message type code.

// Unused low bits of the header flit.
`define NOC_HDR_PAD_W       (`NOC_DATA_WIDTH - (2 * `NOC_XY_W) - `TCP_TX_MSG_TYPE_W \
                             - `TCP_FLOWID_W - `TCP_TX_PTR_W)

`endif

//--- rtl/tcp_tx_pkg.sv
`default_nettype none

`include "tcp_tx_macros.svh"

package tcp_tx_pkg;

    // ************************************************************
    // Message types
    // ************************************************************

    // Codes outside this set are handled as pointer adjustments.
    typedef enum logic [`TCP_TX_MSG_TYPE_W-1:0] {
        TCP_TX_MSG_REQ    = 8'h10,              // Transmit request.
        TCP_TX_ADJUST_PTR = 8'h11               // Tail pointer move.
    } noc_msg_type_e;

    // ************************************************************
    // Header flit from the NoC
    // ************************************************************

    typedef struct packed {
        logic [`NOC_XY_W-1:0]           src_x;      // Sender column.
        logic [`NOC_XY_W-1:0]           src_y;      // Sender row.
        noc_msg_type_e                  msg_type;
        logic [`TCP_FLOWID_W-1:0]       flow_id;
        logic [`TCP_TX_PTR_W-1:0]       tail_ptr;   // New tail for adjust.
        logic [`NOC_HDR_PAD_W-1:0]      padding;
    } noc_hdr_flit_s;

    // ************************************************************
    // Output payloads
    // ************************************************************

    // Poller request, carries the return address.
    typedef struct packed {
        logic [`TCP_FLOWID_W-1:0]       flow_id;
        logic [`NOC_XY_W-1:0]           src_x;
        logic [`NOC_XY_W-1:0]           src_y;
    } poller_msg_req_s;

    // Tail pointer memory write.
    typedef struct packed {
        logic [`TCP_FLOWID_W-1:0]       flow_id;    // Write address.
        logic [`TCP_TX_PTR_W-1:0]       tail_ptr;   // Write data.
    } tail_ptr_wr_s;

    // Scheduler kick for one flow.
    typedef struct packed {
        logic [`TCP_FLOWID_W-1:0]       flow_id;
    } sched_update_s;

endpackage

`default_nettype wire

//--- rtl/tcp_tx_msg_noc_if_in_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "tcp_tx_macros.svh"

module tcp_tx_msg_noc_if_in_ctrl (
    input  logic                        clk,
    input  logic                        rst,

    // NoC input.
    input  logic                        noc_in_val,
    input  logic [`NOC_DATA_WIDTH-1:0]  noc_in_data,
    output logic                        noc_in_rdy,

    // Poller request.
    output logic                        poller_req_val,
    input  logic                        poller_req_rdy,

    // Tail pointer write.
    output logic                        tail_wr_val,
    input  logic                        tail_wr_rdy,

    // Scheduler update.
    output logic                        sched_val,
    input  logic                        sched_rdy,

    // To datapath.
    output logic                        store_hdr_flit
);

    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        REQ_MSG     = 2'd1,
        ADJUST_PTR  = 2'd2,
        KICK_SCHED  = 2'd3
    } state_e;

    tcp_tx_pkg::noc_hdr_flit_s  hdr_flit_cast;

    state_e                     state_reg;
    state_e                     state_next;

    assign hdr_flit_cast = tcp_tx_pkg::noc_hdr_flit_s'(noc_in_data);

    // ************************************************************
    // State register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    // ************************************************************
    // Next state and handshake outputs
    // ************************************************************

    always_comb begin
        noc_in_rdy     = 1'b0;
        poller_req_val = 1'b0;
        tail_wr_val    = 1'b0;
        sched_val      = 1'b0;
        store_hdr_flit = 1'b0;
        state_next     = state_reg;

        case (state_reg)
            IDLE: begin
                noc_in_rdy     = 1'b1;
                store_hdr_flit = 1'b1;                  // Capture every cycle.
                if (noc_in_val) begin
                    if (hdr_flit_cast.msg_type == tcp_tx_pkg::TCP_TX_MSG_REQ) begin
                        state_next = REQ_MSG;
                    end else begin
                        state_next = ADJUST_PTR;        // Any other code.
                    end
                end
            end
            REQ_MSG: begin
                poller_req_val = 1'b1;
                if (poller_req_rdy) begin
                    state_next = IDLE;
                end
            end
            ADJUST_PTR: begin
                tail_wr_val = 1'b1;
                if (tail_wr_rdy) begin
                    state_next = KICK_SCHED;            // Pointer first, then kick.
                end
            end
            KICK_SCHED: begin
                sched_val = 1'b1;
                if (sched_rdy) begin
                    state_next = IDLE;
                end
            end
            default: begin
                noc_in_rdy     = 1'bx;
                poller_req_val = 1'bx;
                tail_wr_val    = 1'bx;
                sched_val      = 1'bx;
                store_hdr_flit = 1'bx;
                state_next     = state_e'(2'bxx);
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/tcp_tx_msg_noc_if_in_datap.sv
`timescale 1ns/1ns
`default_nettype none

`include "tcp_tx_macros.svh"

module tcp_tx_msg_noc_if_in_datap (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [`NOC_DATA_WIDTH-1:0]      noc_in_data,
    input  logic                            store_hdr_flit,

    output tcp_tx_pkg::poller_msg_req_s     poller_req,
    output tcp_tx_pkg::tail_ptr_wr_s        tail_wr,
    output tcp_tx_pkg::sched_update_s       sched_upd
);

    tcp_tx_pkg::noc_hdr_flit_s  hdr_flit_in;
    tcp_tx_pkg::noc_hdr_flit_s  hdr_reg;

    assign hdr_flit_in = tcp_tx_pkg::noc_hdr_flit_s'(noc_in_data);

    // ************************************************************
    // Header register
    // ************************************************************

    // Last load is the accepting edge, held until idle again.
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_reg <= '0;
        end else if (store_hdr_flit) begin
            hdr_reg <= hdr_flit_in;
        end
    end

    // ************************************************************
    // Output payloads
    // ************************************************************

    always_comb begin
        poller_req         = '0;
        poller_req.flow_id = hdr_reg.flow_id;
        poller_req.src_x   = hdr_reg.src_x;             // Reply goes back here.
        poller_req.src_y   = hdr_reg.src_y;
    end

    always_comb begin
        tail_wr          = '0;
        tail_wr.flow_id  = hdr_reg.flow_id;
        tail_wr.tail_ptr = hdr_reg.tail_ptr;
    end

    always_comb begin
        sched_upd         = '0;
        sched_upd.flow_id = hdr_reg.flow_id;            // Same flow as the write.
    end

endmodule

`default_nettype wire

//--- rtl/tcp_tx_msg_noc_if_in.sv
`timescale 1ns/1ns
`default_nettype none

`include "tcp_tx_macros.svh"

module tcp_tx_msg_noc_if_in (
    input  logic                            clk,
    input  logic                            rst,

    // ************************************************************
    // NoC input
    // ************************************************************

    input  logic                            noc_in_val,
    input  logic [`NOC_DATA_WIDTH-1:0]      noc_in_data,
    output logic                            noc_in_rdy,

    // ************************************************************
    // Poller
    // ************************************************************

    output logic                            poller_req_val,
    output tcp_tx_pkg::poller_msg_req_s     poller_req,
    input  logic                            poller_req_rdy,

    // ************************************************************
    // Tail pointer memory
    // ************************************************************

    output logic                            tail_wr_val,
    output tcp_tx_pkg::tail_ptr_wr_s        tail_wr,
    input  logic                            tail_wr_rdy,

    // ************************************************************
    // Scheduler
    // ************************************************************

    output logic                            sched_val,
    output tcp_tx_pkg::sched_update_s       sched_upd,
    input  logic                            sched_rdy
);

    logic store_hdr_flit;                               // High only in idle.

    tcp_tx_msg_noc_if_in_ctrl ctrl (
        .clk            (clk),
        .rst            (rst),

        .noc_in_val     (noc_in_val),
        .noc_in_data    (noc_in_data),
        .noc_in_rdy     (noc_in_rdy),

        .poller_req_val (poller_req_val),
        .poller_req_rdy (poller_req_rdy),

        .tail_wr_val    (tail_wr_val),
        .tail_wr_rdy    (tail_wr_rdy),

        .sched_val      (sched_val),
        .sched_rdy      (sched_rdy),

        .store_hdr_flit (store_hdr_flit)
    );

    tcp_tx_msg_noc_if_in_datap datap (
        .clk            (clk),
        .rst            (rst),

        .noc_in_data    (noc_in_data),
        .store_hdr_flit (store_hdr_flit),

        .poller_req     (poller_req),
        .tail_wr        (tail_wr),
        .sched_upd      (sched_upd)
    );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands just after an edge, like the other inputs.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/tcp_tx_msg_noc_if_in_properties.sv
`timescale 1ns/1ns
`default_nettype none

module tcp_tx_msg_noc_if_in_properties (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            noc_in_rdy,
    input  logic                            poller_req_val,
    input  logic                            poller_req_rdy,
    input  tcp_tx_pkg::poller_msg_req_s     poller_req,
    input  logic                            tail_wr_val,
    input  logic                            tail_wr_rdy,
    input  tcp_tx_pkg::tail_ptr_wr_s        tail_wr,
    input  logic                            sched_val,
    input  logic                            sched_rdy,
    input  tcp_tx_pkg::sched_update_s       sched_upd
);

    int unsigned fail_count = 0;                        // Read by the testbench.

    // ************************************************************
    // Hold under back-pressure
    // ************************************************************

    poller_hold: assert property (@(posedge clk) disable iff (rst)
        poller_req_val && !poller_req_rdy |=> poller_req_val && $stable(poller_req))
        else begin
            fail_count = fail_count + 1;
            $error("poller request not held");
        end

    tail_hold: assert property (@(posedge clk) disable iff (rst)
        tail_wr_val && !tail_wr_rdy |=> tail_wr_val && $stable(tail_wr))
        else begin
            fail_count = fail_count + 1;
            $error("tail write not held");
        end

    sched_hold: assert property (@(posedge clk) disable iff (rst)
        sched_val && !sched_rdy |=> sched_val && $stable(sched_upd))
        else begin
            fail_count = fail_count + 1;
            $error("scheduler update not held");
        end

    // ************************************************************
    // One message at a time
    // ************************************************************

    no_input_while_busy: assert property (@(posedge clk) disable iff (rst)
        !(noc_in_rdy && (poller_req_val || tail_wr_val || sched_val)))
        else begin
            fail_count = fail_count + 1;
            $error("input ready while busy");
        end

    single_output: assert property (@(posedge clk) disable iff (rst)
        $onehot0({poller_req_val, tail_wr_val, sched_val}))
        else begin
            fail_count = fail_count + 1;
            $error("two output valids");
        end

    // Kick only right after the pointer write.
    sched_after_tail: assert property (@(posedge clk) disable iff (rst)
        $rose(sched_val) |-> $past(tail_wr_val && tail_wr_rdy))
        else begin
            fail_count = fail_count + 1;
            $error("scheduler before tail write");
        end

endmodule

bind tcp_tx_msg_noc_if_in tcp_tx_msg_noc_if_in_properties props (
    .clk            (clk),
    .rst            (rst),
    .noc_in_rdy     (noc_in_rdy),
    .poller_req_val (poller_req_val),
    .poller_req_rdy (poller_req_rdy),
    .poller_req     (poller_req),
    .tail_wr_val    (tail_wr_val),
    .tail_wr_rdy    (tail_wr_rdy),
    .tail_wr        (tail_wr),
    .sched_val      (sched_val),
    .sched_rdy      (sched_rdy),
    .sched_upd      (sched_upd)
);

`default_nettype wire

//--- verification/tcp_tx_msg_noc_if_in_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "tcp_tx_macros.svh"

module tcp_tx_msg_noc_if_in_tb;

    localparam int CLK_PERIOD_NS = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int NUM_DIRECTED  = 8;
    localparam int NUM_MSGS      = 60;
    localparam int WATCHDOG_NS   = NUM_MSGS * 40 * CLK_PERIOD_NS;

    localparam logic [`TCP_TX_MSG_TYPE_W-1:0] MSG_REQ    = 8'h10;
    localparam logic [`TCP_TX_MSG_TYPE_W-1:0] MSG_ADJUST = 8'h11;

    // Flit layout, most significant field first.
    typedef struct packed {
        logic [`NOC_XY_W-1:0]           src_x;
        logic [`NOC_XY_W-1:0]           src_y;
        logic [`TCP_TX_MSG_TYPE_W-1:0]  msg_type;
        logic [`TCP_FLOWID_W-1:0]       flow_id;
        logic [`TCP_TX_PTR_W-1:0]       tail_ptr;
        logic [`NOC_HDR_PAD_W-1:0]      padding;
    } hdr_fields_s;

    typedef struct packed {
        logic                           is_req;
        logic [`NOC_XY_W-1:0]           src_x;
        logic [`NOC_XY_W-1:0]           src_y;
        logic [`TCP_FLOWID_W-1:0]       flow_id;
        logic [`TCP_TX_PTR_W-1:0]       tail_ptr;
    } exp_msg_s;

    logic                           clk;
    logic                           rst;
    logic                           noc_in_val;
    logic [`NOC_DATA_WIDTH-1:0]     noc_in_data;
    logic                           noc_in_rdy;
    logic                           poller_req_val;
    tcp_tx_pkg::poller_msg_req_s    poller_req;
    logic                           poller_req_rdy;
    logic                           tail_wr_val;
    tcp_tx_pkg::tail_ptr_wr_s       tail_wr;
    logic                           tail_wr_rdy;
    logic                           sched_val;
    tcp_tx_pkg::sched_update_s      sched_upd;
    logic                           sched_rdy;

    integer         seed;
    hdr_fields_s    hdrs [NUM_MSGS];
    exp_msg_s       exp_q [$];
    logic           tail_done;                          // Adjust write seen and kick due.
    int unsigned    errors;
    int unsigned    n_checked;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) clk_gen (
        .clk (clk),
        .rst (rst)
    );

    tcp_tx_msg_noc_if_in UUT (
        .clk            (clk),
        .rst            (rst),
        .noc_in_val     (noc_in_val),
        .noc_in_data    (noc_in_data),
        .noc_in_rdy     (noc_in_rdy),
        .poller_req_val (poller_req_val),
        .poller_req     (poller_req),
        .poller_req_rdy (poller_req_rdy),
        .tail_wr_val    (tail_wr_val),
        .tail_wr        (tail_wr),
        .tail_wr_rdy    (tail_wr_rdy),
        .sched_val      (sched_val),
        .sched_upd      (sched_upd),
        .sched_rdy      (sched_rdy)
    );

    // ************************************************************
    // Stimulus helpers
    // ************************************************************

    function automatic hdr_fields_s make_header(logic [3:0] x, logic [3:0] y,
                                                logic [7:0] msg_type, logic [7:0] flow,
                                                logic [15:0] ptr);
        hdr_fields_s h;
        h.src_x    = x;
        h.src_y    = y;
        h.msg_type = msg_type;
        h.flow_id  = flow;
        h.tail_ptr = ptr;
        h.padding  = {flow, ptr};                       // Junk the DUT must ignore.
        return h;
    endfunction

    task automatic make_random_header(output hdr_fields_s h);
        logic [31:0] r;
        logic [31:0] sel;
        r   = $random(seed);
        sel = $random(seed);
        h   = make_header(r[3:0], r[7:4], r[15:8], r[23:16], r[31:16] ^ sel[31:16]);
        case (sel[1:0])
            2'd0, 2'd1: h.msg_type = MSG_REQ;
            2'd2:       h.msg_type = MSG_ADJUST;
            default:    h.msg_type = r[15:8];           // Unknown codes too.
        endcase
    endtask

    task automatic build_headers();
        hdrs[0] = make_header(4'h1, 4'h2, MSG_REQ,    8'h01, 16'h0000);
        hdrs[1] = make_header(4'h3, 4'h4, MSG_ADJUST, 8'h02, 16'h1234);
        hdrs[2] = make_header(4'hf, 4'hf, MSG_REQ,    8'hff, 16'hffff);
        hdrs[3] = make_header(4'h0, 4'h0, 8'h00,      8'h7e, 16'hbeef);
        hdrs[4] = make_header(4'ha, 4'h5, 8'hff,      8'h80, 16'h8001);
        hdrs[5] = make_header(4'h6, 4'h9, MSG_REQ,    8'h33, 16'h5555);
        hdrs[6] = make_header(4'h6, 4'h9, MSG_REQ,    8'h34, 16'haaaa);
        hdrs[7] = make_header(4'hc, 4'h3, MSG_ADJUST, 8'h34, 16'h0001);
        for (int i = NUM_DIRECTED; i < NUM_MSGS; i++) begin
            make_random_header(hdrs[i]);
        end
    endtask

    task automatic send_header(hdr_fields_s h);
        noc_in_data = h;
        noc_in_val  = 1'b1;
        @(negedge clk);
        while (!noc_in_rdy) @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        noc_in_val  = 1'b0;
        noc_in_data = ~h;                               // Idle data keeps changing.
    endtask

    // ************************************************************
    // Scoreboard
    // ************************************************************

    function automatic exp_msg_s expect_from(hdr_fields_s h);
        exp_msg_s e;
        e.is_req   = (h.msg_type == MSG_REQ);
        e.src_x    = h.src_x;
        e.src_y    = h.src_y;
        e.flow_id  = h.flow_id;
        e.tail_ptr = h.tail_ptr;
        return e;
    endfunction

    task automatic check_value(string name, logic [31:0] exp_v, logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_poller();
        bit ok;
        ok = (exp_q.size() != 0) && exp_q[0].is_req;
        assert (ok) else begin
            errors++;
            $display("Poller request at %0t without a pending request header", $time);
        end
        if (ok) begin
            check_value("poller_req.flow_id", 32'(exp_q[0].flow_id), 32'(poller_req.flow_id));
            check_value("poller_req.src_x", 32'(exp_q[0].src_x), 32'(poller_req.src_x));
            check_value("poller_req.src_y", 32'(exp_q[0].src_y), 32'(poller_req.src_y));
            void'(exp_q.pop_front());
            n_checked++;
        end
    endtask

    task automatic check_tail();
        bit ok;
        ok = (exp_q.size() != 0) && !exp_q[0].is_req && !tail_done;
        assert (ok) else begin
            errors++;
            $display("Tail write at %0t without a pending adjust header", $time);
        end
        if (ok) begin
            check_value("tail_wr.flow_id", 32'(exp_q[0].flow_id), 32'(tail_wr.flow_id));
            check_value("tail_wr.tail_ptr", 32'(exp_q[0].tail_ptr), 32'(tail_wr.tail_ptr));
            tail_done = 1'b1;
        end
    endtask

    task automatic check_sched();
        bit ok;
        ok = (exp_q.size() != 0) && !exp_q[0].is_req && tail_done;
        assert (ok) else begin
            errors++;
            $display("Scheduler update at %0t without a completed tail write", $time);
        end
        if (ok) begin
            check_value("sched_upd.flow_id", 32'(exp_q[0].flow_id), 32'(sched_upd.flow_id));
            void'(exp_q.pop_front());
            tail_done = 1'b0;
            n_checked++;
        end
    endtask

    // Transfers are sampled mid-cycle before their edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (noc_in_val && noc_in_rdy) begin
                exp_q.push_back(expect_from(hdr_fields_s'(noc_in_data)));
            end
            if (poller_req_val && poller_req_rdy) check_poller();
            if (tail_wr_val && tail_wr_rdy) check_tail();
            if (sched_val && sched_rdy) check_sched();
        end
    end

    // Random back-pressure.
    initial begin
        logic [31:0] r;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            r = $random(seed);
            poller_req_rdy = r[0];
            tail_wr_rdy    = r[1];
            sched_rdy      = r[2];
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired with %0d headers still pending", exp_q.size());
        $display("Test failures found");
        $finish;
    end

    // ************************************************************
    // Main sequence
    // ************************************************************

    initial begin
        seed           = 32'h3a6e_525c;
        noc_in_val     = 1'b0;
        noc_in_data    = '0;
        poller_req_rdy = 1'b0;
        tail_wr_rdy    = 1'b0;
        sched_rdy      = 1'b0;
        tail_done      = 1'b0;
        errors         = 0;
        n_checked      = 0;
        build_headers();                                // All header randoms drawn at time 0.

        @(negedge rst);
        @(negedge clk);
        assert (noc_in_rdy === 1'b1) else begin
            errors++;
            $display("MISMATCH time=%0t noc_in_rdy expected=1 actual=%b", $time, noc_in_rdy);
        end
        assert ({poller_req_val, tail_wr_val, sched_val} === 3'b000) else begin
            errors++;
            $display("Output valid raised right after reset");
        end

        @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < NUM_MSGS; i++) begin
            send_header(hdrs[i]);
            repeat (i % 3) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        assert (n_checked == NUM_MSGS) else begin
            errors++;
            $display("Only %0d of %0d headers completed", n_checked, NUM_MSGS);
        end
        $display("Summary: %0d messages checked, %0d scoreboard errors, %0d protocol errors",
                 n_checked, errors, UUT.props.fail_count);
        if (errors == 0 && UUT.props.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
rtl/tcp_tx_pkg.sv
rtl/tcp_tx_msg_noc_if_in_ctrl.sv
rtl/tcp_tx_msg_noc_if_in_datap.sv
rtl/tcp_tx_msg_noc_if_in.sv
verification/tb_clk_gen.sv
verification/tcp_tx_msg_noc_if_in_properties.sv
verification/tcp_tx_msg_noc_if_in_tb.sv

//--- Makefile
# Verilator build and run for the TCP TX NoC input interface.

VERILATOR   ?= verilator
TOP         ?= tcp_tx_msg_noc_if_in_tb
RTL_TOP     ?= tcp_tx_msg_noc_if_in
FILELIST    ?= verilog.f
INC_DIR     ?= include
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= All tests passed!
VFLAGS      ?= --binary --timing --assert -j 0
SIM_ARGS    ?= +verilator+error+limit+1000

SOURCES     := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter rtl/%,$(SOURCES))
SIM_EXE     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES) $(INC_DIR)/tcp_tx_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(SIM_EXE) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "$(PASS_STRING)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed, see $(LOG)"

lint:
	$(VERILATOR) --lint-only -Wall +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_SOURCES)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
